// ==== vlog.f ====
+incdir+.
huf_sm_pkg.sv
huf_sm_in_fifo.sv
huf_sm_lz77_acc.sv
huf_sm_frame_ctl.sv
huf_sm_sym_out.sv
huf_sm_top.sv
tb_huf_sm.sv

// ==== Makefile ====
TB_TOP = tb_huf_sm

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module huf_sm_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TB_TOP)
	out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// ==== tb_huf_sm_table.svh ====
/*
 * stimulus table for the front-end testbench.
 * one TLV word per row, with the expected close marker of each symbol word.
 */

typedef struct packed {
   logic                  sot;
   logic                  eot;
   huf_sm_pkg::tlv_type_e typen;
   logic [2:0]            framing;
   logic                  backref;
   logic [1:0]            blane;
   logic [15:0]           length;
   logic [31:0]           data;
   logic                  is_sym;
   huf_sm_pkg::eob_e      eob;
} row_s;

localparam huf_sm_pkg::tlv_type_e T_CMD  = huf_sm_pkg::CMD;
localparam huf_sm_pkg::tlv_type_e T_LZ   = huf_sm_pkg::LZ77;
localparam huf_sm_pkg::tlv_type_e T_DATA = huf_sm_pkg::DATA;
localparam huf_sm_pkg::tlv_type_e T_FTR  = huf_sm_pkg::FTR;
localparam huf_sm_pkg::eob_e      MID    = huf_sm_pkg::MIDDLE;
localparam huf_sm_pkg::eob_e      BLK    = huf_sm_pkg::END_BLK;
localparam huf_sm_pkg::eob_e      FRM    = huf_sm_pkg::END_FRM;

localparam int ROWS = 22;

// sot, eot, type, framing, backref, lane, length, data3..data0, symbol, close.
localparam row_s ROW_TABLE [ROWS] = '{
   '{1'b1, 1'b0, T_LZ,   3'd0, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   '{1'b0, 1'b0, T_LZ,   3'd4, 1'b0, 2'd0, 16'h0000, 32'h4443_4241, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd3, 1'b1, 2'd1, 16'h0105, 32'h0063_0061, 1'b1, MID},
   '{1'b0, 1'b1, T_LZ,   3'd2, 1'b0, 2'd0, 16'h0000, 32'h0000_7a79, 1'b1, FRM},
   // command frame, mode word selects XP10.
   '{1'b1, 1'b0, T_CMD,  3'd0, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   '{1'b0, 1'b1, T_CMD,  3'd2, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   // ten symbol words, three blocks.
   '{1'b1, 1'b0, T_LZ,   3'd0, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   '{1'b0, 1'b0, T_LZ,   3'd1, 1'b0, 2'd0, 16'h0000, 32'h0000_0011, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd2, 1'b1, 2'd0, 16'h0010, 32'h0000_2200, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd4, 1'b0, 2'd0, 16'h0000, 32'h8786_8584, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd3, 1'b0, 2'd0, 16'h0000, 32'h0003_0201, 1'b1, BLK},
   '{1'b0, 1'b0, T_LZ,   3'd4, 1'b1, 2'd3, 16'h0203, 32'h0031_3233, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd1, 1'b0, 2'd0, 16'h0000, 32'h0000_00ff, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd2, 1'b0, 2'd0, 16'h0000, 32'h0000_5a5a, 1'b1, MID},
   '{1'b0, 1'b0, T_LZ,   3'd3, 1'b1, 2'd2, 16'h0020, 32'h0000_6b6a, 1'b1, BLK},
   '{1'b0, 1'b0, T_LZ,   3'd4, 1'b0, 2'd0, 16'h0000, 32'ha4a3_a2a1, 1'b1, MID},
   '{1'b0, 1'b1, T_LZ,   3'd1, 1'b0, 2'd0, 16'h0000, 32'h0000_00c0, 1'b1, FRM},
   // frames that are read and dropped.
   '{1'b1, 1'b0, T_DATA, 3'd0, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   '{1'b0, 1'b0, T_DATA, 3'd4, 1'b0, 2'd0, 16'h1234, 32'hdead_beef, 1'b0, MID},
   '{1'b0, 1'b1, T_DATA, 3'd2, 1'b0, 2'd0, 16'h5678, 32'hcafe_f00d, 1'b0, MID},
   '{1'b1, 1'b0, T_FTR,  3'd0, 1'b0, 2'd0, 16'h0000, 32'h0000_0000, 1'b0, MID},
   '{1'b0, 1'b1, T_FTR,  3'd1, 1'b0, 2'd0, 16'h0000, 32'h0badc0de, 1'b0, MID}
};

// ==== tb_huf_sm.sv ====
/*
 * testbench for the huffman front end.
 * table driven TLV stimulus, random sc_rdy, slot release after 16 blocks.
 */
`timescale 1ns/100ps

module tb_huf_sm;

   localparam int WAIT_MAX = 2000;
   localparam int PASSES   = 5;

   logic                  clk;
   logic                  rst_n;
   logic                  in_wr;
   huf_sm_pkg::tlv_word_s in_word;
   logic                  in_rdy;
   logic                  sc_rdy;
   logic                  sym_wr;
   huf_sm_pkg::sym_s      sym;
   logic                  rec_wr;
   huf_sm_pkg::seq_rec_s  rec;
   logic                  rel_vld;
   huf_sm_pkg::seq_id_t   rel_seq_id;

   `include "tb_huf_sm_table.svh"

   huf_sm_pkg::sym_s       exp_sym [$];
   huf_sm_pkg::seq_rec_s   exp_rec [$];
   huf_sm_pkg::comp_mode_e mode_m;
   integer                 seed = 32'h567;
   int                     errors = 0;
   int                     sym_seen = 0;
   int                     rec_seen = 0;
   int                     blk_idx;
   int                     blk_cnt_m;
   int                     raw_m;

   huf_sm_top #(
      .FIFO_DEPTH  (8),
      .WIN_ENTRIES (4)
   ) dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_wr      (in_wr),
      .in_word    (in_word),
      .in_rdy     (in_rdy),
      .sc_rdy     (sc_rdy),
      .sym_wr     (sym_wr),
      .sym        (sym),
      .rec_wr     (rec_wr),
      .rec        (rec),
      .rel_vld    (rel_vld),
      .rel_seq_id (rel_seq_id)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // downstream ready about three cycles in four.
   initial begin
      sc_rdy = 1'b0;
      forever begin
         @(posedge clk);
         sc_rdy <= rst_n && (($random(seed) & 3) != 0);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks and end of run.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("symbols %0d, records %0d, errors %0d", sym_seen, rec_seen, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("timed out waiting for %s", what);
      finish_run();
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus and expected values.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic huf_sm_pkg::tlv_word_s word_for(input row_s r);
      huf_sm_pkg::lz_sym_s   ls;
      huf_sm_pkg::tlv_word_s w;
      ls = '0;
      ls.framing = r.framing;
      ls.backref = r.backref;
      ls.backref_lane = r.blane;
      ls.length = r.length;
      {ls.data3, ls.data2, ls.data1, ls.data0} = r.data;
      w.tdata = huf_sm_pkg::word_t'(ls);
      w.sot = r.sot;
      w.eot = r.eot;
      w.typen = r.typen;
      return w;
   endfunction

   function automatic huf_sm_pkg::sym_s symbol_for(input row_s r, input huf_sm_pkg::seq_id_t id);
      huf_sm_pkg::sym_s  s;
      huf_sm_pkg::lane_t ln [4];
      for (int i = 0; i < 4; i++)
         ln[i] = {1'b0, r.data[8*i +: 8]};
      // match marker in place of the literal.
      if (r.backref)
         ln[r.blane] = {1'b1, r.length[7:0]};
      s.seq_id = id;
      s.vld = 4'((5'd1 << r.framing) - 5'd1);
      s.lane0 = ln[0];
      s.lane1 = ln[1];
      s.lane2 = ln[2];
      s.lane3 = ln[3];
      s.eob = r.eob;
      return s;
   endfunction

   task automatic expect_row(input row_s r);
      huf_sm_pkg::seq_rec_s er;
      huf_sm_pkg::seq_id_t  id;
      id = huf_sm_pkg::seq_id_t'(blk_idx % huf_sm_pkg::SEQ_NUM);
      if (r.sot) begin
         blk_cnt_m = 0;
         raw_m = 0;
      end else if (r.typen == T_CMD) begin
         mode_m = huf_sm_pkg::comp_mode_e'(r.framing);
      end else if (r.is_sym) begin
         exp_sym.push_back(symbol_for(r, id));
         if (r.backref)
            raw_m += int'(r.framing) + int'(r.length) - 1;
         else
            raw_m += int'(r.framing);
         if (r.eob != MID) begin
            er.seq_id = id;
            er.comp_mode = mode_m;
            er.blk_count = 8'(blk_cnt_m);
            er.raw_bytes = 20'(raw_m);
            er.blk_last = (r.eob == FRM);
            exp_rec.push_back(er);
            blk_idx++;
            blk_cnt_m++;
            raw_m = 0;
         end
      end
   endtask

   task automatic drive_row(input row_s r);
      int n;
      n = 0;
      @(negedge clk);
      while (!in_rdy && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!in_rdy) begin
         report_timeout("in_rdy");
      end else begin
         @(posedge clk);
         in_wr   <= 1'b1;
         in_word <= word_for(r);
         @(posedge clk);
         in_wr <= 1'b0;
         expect_row(r);
      end
   endtask

   task automatic drive_all();
      for (int p = 0; p < PASSES; p++)
         for (int r = 0; r < ROWS; r++)
            drive_row(ROW_TABLE[r]);
   endtask

   // all slots held after 16 blocks, slot 0 release resumes output.
   task automatic release_slots();
      int n;
      int held_at;
      n = 0;
      while (rec_seen < huf_sm_pkg::SEQ_NUM && n < WAIT_MAX) begin
         @(posedge clk);
         n++;
      end
      if (rec_seen < huf_sm_pkg::SEQ_NUM) begin
         report_timeout("16 block records");
      end else begin
         held_at = sym_seen;
         repeat (40) @(posedge clk);
         if (sym_seen != held_at) begin
            errors++;
            $display("symbol output went on while all 16 slots were held");
         end
         @(posedge clk);
         rel_vld    <= 1'b1;
         rel_seq_id <= '0;
         @(posedge clk);
         rel_vld <= 1'b0;
         n = 0;
         while (sym_seen == held_at && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
         end
         if (sym_seen == held_at) begin
            report_timeout("symbols after the slot 0 release");
         end else begin
            for (int s = 1; s < huf_sm_pkg::SEQ_NUM; s++) begin
               @(posedge clk);
               rel_vld    <= 1'b1;
               rel_seq_id <= huf_sm_pkg::seq_id_t'(s);
            end
            @(posedge clk);
            rel_vld <= 1'b0;
         end
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // output monitor.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      huf_sm_pkg::sym_s es;
      logic             close_exp;
      forever begin
         @(posedge clk);
         close_exp = 1'b0;
         if (rst_n && sym_wr) begin
            sym_seen++;
            if (exp_sym.size() == 0) begin
               errors++;
               $display("symbol output while none was expected");
            end else begin
               es = exp_sym.pop_front();
               close_exp = (es.eob != MID);
               check_value("sym", 64'(sym), 64'(es));
            end
         end
         // a record goes out with the closing symbol only.
         if (rst_n)
            check_value("rec_wr", 64'(rec_wr), 64'(close_exp));
         if (rst_n && rec_wr) begin
            rec_seen++;
            if (exp_rec.size() == 0) begin
               errors++;
               $display("sequence record while none was expected");
            end else
               check_value("rec", 64'(rec), 64'(exp_rec.pop_front()));
         end
      end
   end

   initial begin
      int n;
      rst_n = 1'b0;
      in_wr = 1'b0;
      in_word = '0;
      rel_vld = 1'b0;
      rel_seq_id = '0;
      mode_m = huf_sm_pkg::NONE;
      blk_idx = 0;
      blk_cnt_m = 0;
      raw_m = 0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("sym_wr", 64'(sym_wr), 64'd0);
      check_value("rec_wr", 64'(rec_wr), 64'd0);
      check_value("in_rdy", 64'(in_rdy), 64'd1);
      fork
         drive_all();
         release_slots();
      join
      n = 0;
      while ((exp_sym.size() != 0 || exp_rec.size() != 0) && n < WAIT_MAX) begin
         @(posedge clk);
         n++;
      end
      if (exp_sym.size() != 0 || exp_rec.size() != 0) begin
         report_timeout("the remaining outputs");
      end else begin
         repeat (20) @(posedge clk);
         finish_run();
      end
   end

endmodule

// ==== huf_sm_top.sv ====
/*
 * huffman compressor front end.
 * staging FIFO, frame control, LZ77 accounting and output registers.
 */
`timescale 1ns/100ps

module huf_sm_top #(
   parameter int FIFO_DEPTH  = 8,
   parameter int WIN_ENTRIES = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_wr,
   input  huf_sm_pkg::tlv_word_s in_word,
   output logic                  in_rdy,
   input  logic                  sc_rdy,
   output logic                  sym_wr,
   output huf_sm_pkg::sym_s      sym,
   output logic                  rec_wr,
   output huf_sm_pkg::seq_rec_s  rec,
   input  logic                  rel_vld,
   input  huf_sm_pkg::seq_id_t   rel_seq_id
);

   huf_sm_pkg::tlv_word_s head;
   logic                  empty;
   logic [3:0]            used;
   logic                  pop;
   logic                  acc_en;
   logic                  acc_clr;
   logic                  blk_clr;
   huf_sm_pkg::sym_s      sym_nxt;
   huf_sm_pkg::eob_e      close;
   huf_sm_pkg::raw_cnt_t  raw_bytes;
   huf_sm_pkg::blk_cnt_t  blk_count;
   logic                  emit;
   huf_sm_pkg::sym_s      sym_c;
   logic                  rec_emit;
   huf_sm_pkg::seq_rec_s  rec_c;

   huf_sm_in_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_in_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (in_wr),
      .wdata (in_word),
      .pop   (pop),
      .head  (head),
      .empty (empty),
      .rdy   (in_rdy),
      .used  (used)
   );

   huf_sm_frame_ctl u_frame_ctl (
      .clk        (clk),
      .rst_n      (rst_n),
      .head       (head),
      .empty      (empty),
      .used       (used),
      .sc_rdy     (sc_rdy),
      .rel_vld    (rel_vld),
      .rel_seq_id (rel_seq_id),
      .close      (close),
      .sym_nxt    (sym_nxt),
      .raw_bytes  (raw_bytes),
      .blk_count  (blk_count),
      .pop        (pop),
      .acc_en     (acc_en),
      .acc_clr    (acc_clr),
      .blk_clr    (blk_clr),
      .emit       (emit),
      .sym_o      (sym_c),
      .rec_emit   (rec_emit),
      .rec_o      (rec_c)
   );

   huf_sm_lz77_acc #(
      .WIN_ENTRIES (WIN_ENTRIES)
   ) u_lz77_acc (
      .clk       (clk),
      .rst_n     (rst_n),
      .acc_en    (acc_en),
      .acc_clr   (acc_clr),
      .blk_clr   (blk_clr),
      .word      (head.tdata),
      .eot       (head.eot),
      .sym_nxt   (sym_nxt),
      .close     (close),
      .raw_bytes (raw_bytes),
      .blk_count (blk_count)
   );

   huf_sm_sym_out u_sym_out (
      .clk      (clk),
      .rst_n    (rst_n),
      .emit     (emit),
      .sym_i    (sym_c),
      .rec_emit (rec_emit),
      .rec_i    (rec_c),
      .sym_wr   (sym_wr),
      .sym      (sym),
      .rec_wr   (rec_wr),
      .rec      (rec)
   );

endmodule

// ==== huf_sm_sym_out.sv ====
/*
 * output register stage.
 * symbol strobe to the symbol counter and per-block sequence record.
 */
`timescale 1ns/100ps

module huf_sm_sym_out (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 emit,
   input  huf_sm_pkg::sym_s     sym_i,
   input  logic                 rec_emit,
   input  huf_sm_pkg::seq_rec_s rec_i,
   output logic                 sym_wr,
   output huf_sm_pkg::sym_s     sym,
   output logic                 rec_wr,
   output huf_sm_pkg::seq_rec_s rec
);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sym_wr <= 1'b0;
         rec_wr <= 1'b0;
      end else begin
         sym_wr <= emit;
         rec_wr <= rec_emit;
      end
   end

   // payloads only move with their strobe.
   always_ff @(posedge clk) begin
      if (emit)
         sym <= sym_i;
      if (rec_emit) begin
         rec          <= rec_i;
         rec.blk_last <= (sym_i.eob == huf_sm_pkg::END_FRM);
      end
   end

   a_rec_with_sym: assert property (@(posedge clk) disable iff (!rst_n)
      rec_wr |-> sym_wr);

   // every closing symbol carries its record for the same slot.
   a_close_has_rec: assert property (@(posedge clk) disable iff (!rst_n)
      (sym_wr && sym.eob != huf_sm_pkg::MIDDLE) |-> (rec_wr && rec.seq_id == sym.seq_id));

endmodule

// ==== huf_sm_frame_ctl.sv ====
/*
 * frame state machine.
 * classifies frames, captures compression mode, tracks sequence slots.
 */
`timescale 1ns/100ps

module huf_sm_frame_ctl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  huf_sm_pkg::tlv_word_s head,
   input  logic                  empty,
   input  logic [3:0]            used,
   input  logic                  sc_rdy,
   input  logic                  rel_vld,
   input  huf_sm_pkg::seq_id_t   rel_seq_id,
   input  huf_sm_pkg::eob_e      close,
   input  huf_sm_pkg::sym_s      sym_nxt,
   input  huf_sm_pkg::raw_cnt_t  raw_bytes,
   input  huf_sm_pkg::blk_cnt_t  blk_count,
   output logic                  pop,
   output logic                  acc_en,
   output logic                  acc_clr,
   output logic                  blk_clr,
   output logic                  emit,
   output huf_sm_pkg::sym_s      sym_o,
   output logic                  rec_emit,
   output huf_sm_pkg::seq_rec_s  rec_o
);

   huf_sm_pkg::sm_state_e          state;
   huf_sm_pkg::comp_mode_e         comp_mode;
   huf_sm_pkg::seq_id_t            slot;
   logic [huf_sm_pkg::SEQ_NUM-1:0] active;
   logic                           blk_first;
   logic                           held;
   logic                           stall;
   logic                           blk_end;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // word consumption.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // a release for the current slot lets the block start now.
   assign held  = active[slot] & ~(rel_vld & (rel_seq_id == slot));
   assign stall = (state == huf_sm_pkg::SM_LZ77) & blk_first & held;

   assign pop     = ~empty & sc_rdy & ~stall;
   assign acc_clr = pop & (state == huf_sm_pkg::SM_FRM_IDL) & head.sot;
   assign acc_en  = pop & (state == huf_sm_pkg::SM_LZ77);
   assign blk_end = acc_en & (close != huf_sm_pkg::MIDDLE);

   assign emit     = acc_en;
   assign rec_emit = blk_end;
   assign blk_clr  = blk_end;

   always_comb begin
      sym_o        = sym_nxt;
      sym_o.seq_id = slot;
   end

   // blk_last is filled in at the output stage.
   always_comb begin
      rec_o           = '0;
      rec_o.seq_id    = slot;
      rec_o.comp_mode = comp_mode;
      rec_o.blk_count = blk_count;
      rec_o.raw_bytes = raw_bytes;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // state and slot tracking.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= huf_sm_pkg::SM_FRM_IDL;
         comp_mode <= huf_sm_pkg::NONE;
         slot      <= '0;
         active    <= '0;
         blk_first <= 1'b1;
      end else begin
         if (rel_vld)
            active[rel_seq_id] <= 1'b0;
         if (pop) begin
            case (state)
               huf_sm_pkg::SM_FRM_IDL: begin
                  // stray non-sot words are dropped here.
                  if (head.sot && !head.eot) begin
                     case (head.typen)
                        huf_sm_pkg::CMD:  state <= huf_sm_pkg::SM_CMD;
                        huf_sm_pkg::LZ77: state <= huf_sm_pkg::SM_LZ77;
                        default:          state <= huf_sm_pkg::SM_SKIP;
                     endcase
                  end
               end
               huf_sm_pkg::SM_CMD: begin
                  comp_mode <= huf_sm_pkg::comp_mode_e'(head.tdata[2:0]);
                  state     <= head.eot ? huf_sm_pkg::SM_FRM_IDL : huf_sm_pkg::SM_SKIP;
               end
               huf_sm_pkg::SM_LZ77: begin
                  if (blk_first) begin
                     active[slot] <= 1'b1;
                     blk_first    <= 1'b0;
                  end
                  // slot moves on at every block close.
                  if (close != huf_sm_pkg::MIDDLE) begin
                     slot      <= slot + 1'b1;
                     blk_first <= 1'b1;
                  end
                  if (head.eot)
                     state <= huf_sm_pkg::SM_FRM_IDL;
               end
               default: begin
                  if (head.eot)
                     state <= huf_sm_pkg::SM_FRM_IDL;
               end
            endcase
         end
      end
   end

endmodule

// ==== huf_sm_lz77_acc.sv ====
/*
 * LZ77 symbol word decode and block accounting.
 * builds lane strobes, tracks raw bytes and entries, decides block close.
 */
`timescale 1ns/100ps

module huf_sm_lz77_acc #(
   parameter int WIN_ENTRIES = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  acc_en,
   input  logic                  acc_clr,
   input  logic                  blk_clr,
   input  huf_sm_pkg::word_t     word,
   input  logic                  eot,
   output huf_sm_pkg::sym_s      sym_nxt,
   output huf_sm_pkg::eob_e      close,
   output huf_sm_pkg::raw_cnt_t  raw_bytes,
   output huf_sm_pkg::blk_cnt_t  blk_count
);

   huf_sm_pkg::lz_sym_s    lz;
   huf_sm_pkg::raw_cnt_t   raw_cnt;
   huf_sm_pkg::raw_cnt_t   raw_add;
   huf_sm_pkg::entry_cnt_t entry_cnt;
   huf_sm_pkg::entry_cnt_t entry_nxt;

   assign lz = huf_sm_pkg::lz_sym_s'(word);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // lanes.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      sym_nxt = '0;
      case (lz.framing)
         3'd1:    sym_nxt.vld = 4'b0001;
         3'd2:    sym_nxt.vld = 4'b0011;
         3'd3:    sym_nxt.vld = 4'b0111;
         3'd4:    sym_nxt.vld = 4'b1111;
         default: sym_nxt.vld = 4'b0000;
      endcase
      sym_nxt.lane0 = {1'b0, lz.data0};
      sym_nxt.lane1 = {1'b0, lz.data1};
      sym_nxt.lane2 = {1'b0, lz.data2};
      sym_nxt.lane3 = {1'b0, lz.data3};
      // match marker replaces the literal.
      if (lz.backref) begin
         case (lz.backref_lane)
            2'd0: sym_nxt.lane0 = {1'b1, lz.length[7:0]};
            2'd1: sym_nxt.lane1 = {1'b1, lz.length[7:0]};
            2'd2: sym_nxt.lane2 = {1'b1, lz.length[7:0]};
            default: sym_nxt.lane3 = {1'b1, lz.length[7:0]};
         endcase
      end
      sym_nxt.eob = close;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // accounting.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      if (lz.backref)
         raw_add = huf_sm_pkg::raw_cnt_t'(lz.framing) + huf_sm_pkg::raw_cnt_t'(lz.length)
                   - huf_sm_pkg::raw_cnt_t'(1);
      else
         raw_add = huf_sm_pkg::raw_cnt_t'(lz.framing);
   end

   assign raw_bytes = raw_cnt + raw_add;
   assign entry_nxt = entry_cnt + 1'b1;

   always_comb begin
      if (eot)
         close = huf_sm_pkg::END_FRM;
      else if (entry_nxt == huf_sm_pkg::entry_cnt_t'(WIN_ENTRIES))
         close = huf_sm_pkg::END_BLK;
      else
         close = huf_sm_pkg::MIDDLE;
   end

   always_ff @(posedge clk) begin
      if (!rst_n || acc_clr) begin
         raw_cnt   <= '0;
         entry_cnt <= '0;
         blk_count <= '0;
      end else if (blk_clr) begin
         raw_cnt   <= '0;
         entry_cnt <= '0;
         blk_count <= blk_count + 1'b1;
      end else if (acc_en) begin
         raw_cnt   <= raw_bytes;
         entry_cnt <= entry_nxt;
      end
   end

   a_framing: assert property (@(posedge clk) disable iff (!rst_n)
      acc_en |-> (lz.framing inside {[3'd1:3'd4]}));

endmodule

// ==== huf_sm_in_fifo.sv ====
/*
 * staging FIFO for incoming TLV words.
 * oldest entry shown at head, occupancy and not-full level out.
 */
`timescale 1ns/100ps

module huf_sm_in_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  wr,
   input  huf_sm_pkg::tlv_word_s wdata,
   input  logic                  pop,
   output huf_sm_pkg::tlv_word_s head,
   output logic                  empty,
   output logic                  rdy,
   output logic [3:0]            used
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   huf_sm_pkg::tlv_word_s mem [FIFO_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;

   // wraps for any depth.
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      return p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (wr)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({wr, pop})
            2'b10:   used <= used + 4'd1;
            2'b01:   used <= used - 4'd1;
            default: used <= used;
         endcase
      end
   end

   assign head  = mem[rd_ptr];
   assign empty = (used == 4'd0);
   assign rdy   = (used != 4'(FIFO_DEPTH));

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr |-> rdy);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// ==== huf_sm_pkg.sv ====
/*
 * huffman compressor front end, shared definitions.
 * widths, TLV word and symbol record layouts, state encodings.
 */
package huf_sm_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // widths.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [63:0] word_t;
   typedef logic [3:0]  seq_id_t;
   typedef logic [19:0] raw_cnt_t;
   typedef logic [7:0]  entry_cnt_t;
   typedef logic [8:0]  lane_t;
   typedef logic [7:0]  blk_cnt_t;

   // number of sequence slots.
   localparam int SEQ_NUM = 2 ** $bits(seq_id_t);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // encodings.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [3:0] {
      CMD  = 4'h1,
      LZ77 = 4'h2,
      DATA = 4'h3,
      FTR  = 4'h4,
      OTHR = 4'hf
   } tlv_type_e;

   typedef enum logic [2:0] {
      NONE = 3'd0,
      XP9  = 3'd1,
      XP10 = 3'd2,
      ZLIB = 3'd3,
      GZIP = 3'd4
   } comp_mode_e;

   typedef enum logic [1:0] {
      MIDDLE  = 2'd0,
      END_BLK = 2'd1,
      END_FRM = 2'd2
   } eob_e;

   typedef enum logic [2:0] {
      SM_FRM_IDL,
      SM_CMD,
      SM_LZ77,
      SM_SKIP
   } sm_state_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // words and records.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // typen only valid with sot.
   typedef struct packed {
      word_t     tdata;
      logic      sot;
      logic      eot;
      tlv_type_e typen;
   } tlv_word_s;

   // symbol word layout, framing in the low bits.
   typedef struct packed {
      logic [9:0]  spare;
      logic [15:0] length;
      logic [7:0]  data3;
      logic [7:0]  data2;
      logic [7:0]  data1;
      logic [7:0]  data0;
      logic [1:0]  backref_lane;
      logic        backref;
      logic [2:0]  framing;
   } lz_sym_s;

   typedef struct packed {
      seq_id_t    seq_id;
      logic [3:0] vld;
      lane_t      lane0;
      lane_t      lane1;
      lane_t      lane2;
      lane_t      lane3;
      eob_e       eob;
   } sym_s;

   typedef struct packed {
      seq_id_t    seq_id;
      comp_mode_e comp_mode;
      blk_cnt_t   blk_count;
      raw_cnt_t   raw_bytes;
      logic       blk_last;
   } seq_rec_s;

endpackage
